/* logic/dot_pkg.sv */
// Shared sizes and types for the four-lane int8 dot-product engine
// Beat, kernel-write and result structs plus the kernel word union

package dot_pkg;

    // ------------------------------------------------------------------------
    // Sizes
    // ------------------------------------------------------------------------
    localparam int ELEM_W       = 8;                   // One int8 element
    localparam int ELEMS        = 16;                  // Elements per beat
    localparam int HALF_ELEMS   = ELEMS / 2;           // Elements per kernel write
    localparam int NUM_LANES    = 4;                   // Lanes in the chain
    localparam int KERNEL_DEPTH = 64;                  // Up to 1024 elements per kernel
    localparam int RD_ADDR_W    = $clog2(KERNEL_DEPTH);
    localparam int WR_ADDR_W    = RD_ADDR_W + 1;       // LSB picks the half
    localparam int LANE_ID_W    = $clog2(NUM_LANES);
    localparam int ACC_W        = 32;
    localparam int RES_W        = 16;                  // Result slice width
    localparam int RES_SHIFT    = 8;                   // Divide by 256

    // ------------------------------------------------------------------------
    // Basic types
    // ------------------------------------------------------------------------
    typedef logic signed [ELEM_W-1:0] elem_t;
    typedef elem_t [HALF_ELEMS-1:0]   half_t;         // 64-bit write half
    typedef elem_t [ELEMS-1:0]        vec_t;          // 128-bit activation beat
    typedef logic [RD_ADDR_W-1:0]     rd_addr_t;
    typedef logic [WR_ADDR_W-1:0]     wr_addr_t;
    typedef logic [LANE_ID_W-1:0]     lane_id_t;
    typedef logic signed [ACC_W-1:0]  acc_t;
    typedef logic [RES_W-1:0]         res_t;

    // Beat moving down the lane chain
    typedef struct packed {
        vec_t     a;        // Activations
        rd_addr_t rd_addr;  // Kernel word for this beat
        logic     first;    // Load accumulator
        logic     last;     // Final beat of product
        logic     active;   // Inside first..last window
    } beat_t;

    // Kernel half-word write, broadcast to all lanes
    typedef struct packed {
        logic     en;
        lane_id_t lane;     // Target lane
        wr_addr_t addr;     // Half-word address
        half_t    data;
    } wr_cmd_t;

    // One kernel word, written by halves and multiplied by elements
    typedef union packed {
        half_t [1:0] halves;  // Write view, half 0 is elements 0..7
        vec_t        elems;   // Multiply view
    } kernel_word_u;

    // Packed lane results, lane 0 in the low slot
    typedef struct packed {
        res_t [NUM_LANES-1:0] lane;
    } result_word_t;

endpackage

/* logic/dot_input_stage.sv */
// Input stage of the dot-product engine
// Registers port inputs, tracks the product window and runs the read address

`timescale 1ns/1ps

module dot_input_stage (
    input  logic                i_clk,
    input  logic                i_rst,
    input  logic                i_wr_en,
    input  dot_pkg::lane_id_t   i_wr_lane,
    input  dot_pkg::wr_addr_t   i_wr_addr,
    input  dot_pkg::half_t      i_wr_data,
    input  dot_pkg::vec_t       i_a,
    input  logic                i_first,
    input  logic                i_last,
    output dot_pkg::wr_cmd_t    o_wr,
    output dot_pkg::beat_t      o_beat
);

    dot_pkg::vec_t a_q;         // Captured activations
    logic          first_q;
    logic          last_q;
    logic          in_prod;     // Product continues past first beat
    logic          active_now;  // Captured beat is inside the window
    logic          win_open;    // Next port beat still belongs to product

    // ------------------------------------------------------------------------
    // Port capture
    // ------------------------------------------------------------------------
    always_ff @(posedge i_clk) begin
        a_q       <= i_a;
        o_wr.lane <= i_wr_lane;
        o_wr.addr <= i_wr_addr;
        o_wr.data <= i_wr_data;
        if (i_rst) begin
            first_q <= 1'b0;
            last_q  <= 1'b0;
            o_wr.en <= 1'b0;
        end else begin
            first_q <= i_first;
            last_q  <= i_last;
            o_wr.en <= i_wr_en;  // Lane match happens in each lane
        end
    end

    assign active_now = first_q | in_prod;
    assign win_open   = active_now & ~last_q;

    // ------------------------------------------------------------------------
    // Beat register and read address counter
    // ------------------------------------------------------------------------
    always_ff @(posedge i_clk) begin
        o_beat.a <= a_q;
        if (first_q) begin
            o_beat.rd_addr <= '0;                                   // Kernel starts at word 0
        end else if (in_prod) begin
            o_beat.rd_addr <= o_beat.rd_addr + dot_pkg::rd_addr_t'(1);
        end
        if (i_rst) begin
            in_prod       <= 1'b0;
            o_beat.first  <= 1'b0;
            o_beat.last   <= 1'b0;
            o_beat.active <= 1'b0;
        end else begin
            in_prod       <= win_open;
            o_beat.first  <= first_q;
            o_beat.last   <= last_q & active_now;
            o_beat.active <= active_now;
        end
    end

    // Kernel writes only between products
    a_no_wr_in_prod: assert property (@(posedge i_clk) disable iff (i_rst)
        i_wr_en |-> !(i_first || win_open));

    // New product only after the previous last beat
    a_first_after_last: assert property (@(posedge i_clk) disable iff (i_rst)
        i_first |-> !win_open);

endmodule

/* logic/dot_kernel_bank.sv */
// Kernel memory of one lane
// Written in 64-bit halves, read as a full 128-bit word with one cycle latency

`timescale 1ns/1ps

module dot_kernel_bank (
    input  logic                    i_clk,
    input  logic                    i_wr_en,
    input  dot_pkg::wr_addr_t       i_wr_addr,
    input  dot_pkg::half_t          i_wr_data,
    input  dot_pkg::rd_addr_t       i_rd_addr,
    output dot_pkg::kernel_word_u   o_rd_word
);

    dot_pkg::kernel_word_u mem [dot_pkg::KERNEL_DEPTH];  // One word per beat

    dot_pkg::rd_addr_t wr_word;  // Word part of the half address
    logic              wr_half;  // 0 is elements 0..7

    assign wr_word = i_wr_addr[dot_pkg::WR_ADDR_W-1:1];
    assign wr_half = i_wr_addr[0];

    // ------------------------------------------------------------------------
    // Write port, one half per cycle
    // ------------------------------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (i_wr_en) begin
            mem[wr_word].halves[wr_half] <= i_wr_data;  // Other half keeps its value
        end
    end

    // ------------------------------------------------------------------------
    // Read port, every cycle
    // ------------------------------------------------------------------------
    always_ff @(posedge i_clk) begin
        o_rd_word <= mem[i_rd_addr];  // Lines up with the lane's beat register
    end

endmodule

/* logic/dot_lane.sv */
// One lane of the dot-product chain
// Kernel read, 16-way signed multiply-sum, accumulator and beat forwarding

`timescale 1ns/1ps

module dot_lane #(
    parameter int LANE_ID = 0
) (
    input  logic                i_clk,
    input  logic                i_rst,
    input  dot_pkg::wr_cmd_t    i_wr,
    input  dot_pkg::beat_t      i_beat,
    output dot_pkg::beat_t      o_beat,
    output dot_pkg::res_t       o_result,
    output logic                o_done
);

    logic                  bank_wr_en;  // Write aimed at this lane
    dot_pkg::kernel_word_u rd_word;     // Kernel word for o_beat
    dot_pkg::acc_t         mac_sum;     // Combinational 16-way sum
    dot_pkg::acc_t         prod_q;      // Registered sum
    logic                  s2_first;
    logic                  s2_last;
    logic                  s2_active;
    dot_pkg::acc_t         acc;

    // ------------------------------------------------------------------------
    // Kernel bank
    // ------------------------------------------------------------------------
    assign bank_wr_en = i_wr.en && (i_wr.lane == dot_pkg::lane_id_t'(LANE_ID));

    dot_kernel_bank u_bank (
        .i_clk     (i_clk),
        .i_wr_en   (bank_wr_en),
        .i_wr_addr (i_wr.addr),
        .i_wr_data (i_wr.data),
        .i_rd_addr (i_beat.rd_addr),  // Staggered by the chain itself
        .o_rd_word (rd_word)
    );

    // ------------------------------------------------------------------------
    // Forwarding register
    // ------------------------------------------------------------------------
    // Doubles as the one-cycle delay on a that meets the read word
    always_ff @(posedge i_clk) begin
        o_beat.a       <= i_beat.a;
        o_beat.rd_addr <= i_beat.rd_addr;
        if (i_rst) begin
            o_beat.first  <= 1'b0;
            o_beat.last   <= 1'b0;
            o_beat.active <= 1'b0;
        end else begin
            o_beat.first  <= i_beat.first;
            o_beat.last   <= i_beat.last;
            o_beat.active <= i_beat.active;
        end
    end

    // ------------------------------------------------------------------------
    // Multiply-sum
    // ------------------------------------------------------------------------
    always_comb begin
        mac_sum = '0;
        for (int j = 0; j < dot_pkg::ELEMS; j++) begin
            // Both operands sign extended before the multiply
            mac_sum = mac_sum + dot_pkg::acc_t'(o_beat.a[j])
                              * dot_pkg::acc_t'(rd_word.elems[j]);
        end
    end

    always_ff @(posedge i_clk) begin
        prod_q <= mac_sum;
        if (i_rst) begin
            s2_first  <= 1'b0;
            s2_last   <= 1'b0;
            s2_active <= 1'b0;
        end else begin
            s2_first  <= o_beat.first;
            s2_last   <= o_beat.last;
            s2_active <= o_beat.active;
        end
    end

    // ------------------------------------------------------------------------
    // Accumulator
    // ------------------------------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (s2_active) begin
            acc <= s2_first ? prod_q : acc + prod_q;  // First beat loads
        end
        if (i_rst) begin
            o_done <= 1'b0;
        end else begin
            o_done <= s2_active & s2_last;  // Same cycle as final update
        end
    end

    assign o_result = acc[dot_pkg::RES_SHIFT +: dot_pkg::RES_W];  // Sum / 256

    // Too many beats would wrap the count back to word 0 mid-product
    a_rd_addr_range: assert property (@(posedge i_clk) disable iff (i_rst)
        i_beat.active |-> (i_beat.first || i_beat.rd_addr != '0));

endmodule

/* logic/dot_result_collect.sv */
// Result collector for the lane chain
// Skews each lane's result to line up with the last lane, then emits one word

`timescale 1ns/1ps

module dot_result_collect (
    input  logic                                         i_clk,
    input  logic                                         i_rst,
    input  dot_pkg::res_t [dot_pkg::NUM_LANES-1:0]       i_result,
    input  logic [dot_pkg::NUM_LANES-1:0]                i_done,
    output dot_pkg::result_word_t                        o_sum,
    output logic                                         o_valid
);

    dot_pkg::res_t [dot_pkg::NUM_LANES-1:0] aligned;  // Holding word, one product

    // ------------------------------------------------------------------------
    // Per-lane holding slots
    // ------------------------------------------------------------------------
    // Lane k finishes k cycles after lane 0, so earlier lanes wait longer
    for (genvar k = 0; k < dot_pkg::NUM_LANES; k++) begin : g_slot
        if (k == dot_pkg::NUM_LANES - 1) begin : g_direct
            assign aligned[k] = i_result[k];  // Last lane closes the word
        end else begin : g_skew
            dot_pkg::res_t skew [dot_pkg::NUM_LANES-1-k];

            always_ff @(posedge i_clk) begin
                if (i_done[k]) begin
                    skew[0] <= i_result[k];  // Latch on this lane's done
                end
                for (int j = 1; j < dot_pkg::NUM_LANES - 1 - k; j++) begin
                    skew[j] <= skew[j-1];
                end
            end

            assign aligned[k] = skew[dot_pkg::NUM_LANES-2-k];
        end

        // Done walks down the chain one lane per cycle
        if (k > 0) begin : g_order
            a_done_order: assert property (@(posedge i_clk) disable iff (i_rst)
                i_done[k] == $past(i_done[k-1]));
        end
    end

    // ------------------------------------------------------------------------
    // Output word
    // ------------------------------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (i_done[dot_pkg::NUM_LANES-1]) begin
            o_sum.lane <= aligned;
        end
        if (i_rst) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_done[dot_pkg::NUM_LANES-1];  // Single-cycle pulse
        end
    end

endmodule

/* logic/dot_product_top.sv */
// Four-lane int8 dot-product engine
// Input stage, lane chain and result collector

`timescale 1ns/1ps

module dot_product_top (
    input  logic                    i_clk,
    input  logic                    i_rst,
    // Kernel write
    input  logic                    i_wr_en,
    input  dot_pkg::lane_id_t       i_wr_lane,
    input  dot_pkg::wr_addr_t       i_wr_addr,
    input  dot_pkg::half_t          i_wr_data,
    // Activation beat
    input  dot_pkg::vec_t           i_a,
    input  logic                    i_first,
    input  logic                    i_last,
    // Result
    output dot_pkg::result_word_t   o_sum,
    output logic                    o_valid
);

    dot_pkg::wr_cmd_t                       wr;                       // Broadcast write
    dot_pkg::beat_t                         beat [dot_pkg::NUM_LANES]; // Beat into lane k
    dot_pkg::res_t [dot_pkg::NUM_LANES-1:0] lane_res;
    logic [dot_pkg::NUM_LANES-1:0]          lane_done;

    dot_input_stage u_input (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_wr_en   (i_wr_en),
        .i_wr_lane (i_wr_lane),
        .i_wr_addr (i_wr_addr),
        .i_wr_data (i_wr_data),
        .i_a       (i_a),
        .i_first   (i_first),
        .i_last    (i_last),
        .o_wr      (wr),
        .o_beat    (beat[0])
    );

    // Lane chain, the tail lane's beat goes nowhere
    for (genvar k = 0; k < dot_pkg::NUM_LANES; k++) begin : g_lane
        if (k < dot_pkg::NUM_LANES - 1) begin : g_fwd
            dot_lane #(.LANE_ID(k)) u_lane (
                .i_clk (i_clk), .i_rst (i_rst), .i_wr (wr), .i_beat (beat[k]),
                .o_beat (beat[k+1]), .o_result (lane_res[k]), .o_done (lane_done[k])
            );
        end else begin : g_tail
            dot_lane #(.LANE_ID(k)) u_lane (
                .i_clk (i_clk), .i_rst (i_rst), .i_wr (wr), .i_beat (beat[k]),
                .o_beat (), .o_result (lane_res[k]), .o_done (lane_done[k])
            );
        end
    end

    dot_result_collect u_collect (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .i_result (lane_res),
        .i_done   (lane_done),
        .o_sum    (o_sum),
        .o_valid  (o_valid)
    );

endmodule

/* verification/dot_product_tb.sv */
// Testbench for the four-lane int8 dot-product engine
// Random and extreme kernels and activations checked against a behavioral model

`timescale 1ns/1ps

module dot_product_tb;

    // ------------------------------------------------------------------------
    // Test sizes and run budget
    // ------------------------------------------------------------------------
    localparam int CLK_PERIOD = 20;
    localparam int LATENCY    = 8;                     // i_last sample edge to o_valid
    localparam int N_SINGLE   = 8;
    localparam int N_MULTI    = 10;
    localparam int N_B2B      = 6;                     // Back-to-back products
    localparam int N_EXTREME  = 4;
    localparam int N_PRODUCTS = N_SINGLE + N_MULTI + N_B2B + N_EXTREME;
    localparam int DRAIN      = 12;                    // Idle cycles after a product
    localparam int WR_CYCLES  = 2 * dot_pkg::NUM_LANES * 2 * dot_pkg::KERNEL_DEPTH;
    localparam int MAX_BEATS  = N_SINGLE
                              + (N_MULTI + N_B2B + N_EXTREME) * dot_pkg::KERNEL_DEPTH;
    localparam int RUN_CYCLES = WR_CYCLES + MAX_BEATS + N_PRODUCTS * DRAIN;

    // DUT ports
    logic                  i_clk = 1'b0;
    logic                  i_rst;
    logic                  i_wr_en;
    dot_pkg::lane_id_t     i_wr_lane;
    dot_pkg::wr_addr_t     i_wr_addr;
    dot_pkg::half_t        i_wr_data;
    dot_pkg::vec_t         i_a;
    logic                  i_first;
    logic                  i_last;
    dot_pkg::result_word_t o_sum;
    logic                  o_valid;

    // Model state
    dot_pkg::vec_t         kern [dot_pkg::NUM_LANES][dot_pkg::KERNEL_DEPTH];  // Kernel copy
    dot_pkg::vec_t         act  [dot_pkg::KERNEL_DEPTH];  // Beats of the next product
    dot_pkg::result_word_t exp_q [$];                      // Expected words, in order
    int                    valid_at [$];                   // Edge count of each o_valid
    int                    edge_count = 0;
    int                    n_checked = 0;
    logic                  exp_valid;
    dot_pkg::result_word_t exp_word;

    always #(CLK_PERIOD / 2) i_clk = ~i_clk;

    always @(posedge i_clk) edge_count = edge_count + 1;  // Read only off the edge

    dot_product_top dut_i (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_wr_en   (i_wr_en),
        .i_wr_lane (i_wr_lane),
        .i_wr_addr (i_wr_addr),
        .i_wr_data (i_wr_data),
        .i_a       (i_a),
        .i_first   (i_first),
        .i_last    (i_last),
        .o_sum     (o_sum),
        .o_valid   (o_valid)
    );

    // ------------------------------------------------------------------------
    // Reference model and checks
    // ------------------------------------------------------------------------
    function automatic dot_pkg::vec_t rand_vec();
        return {$urandom, $urandom, $urandom, $urandom};
    endfunction

    // Signed dot product per lane over n beats, then bits 23:8
    function automatic dot_pkg::result_word_t ref_dot(input int n);
        dot_pkg::result_word_t r;
        int                    sum;
        logic [31:0]           sum_u;
        for (int l = 0; l < dot_pkg::NUM_LANES; l++) begin
            sum = 0;
            for (int b = 0; b < n; b++) begin
                for (int j = 0; j < dot_pkg::ELEMS; j++) begin
                    sum += int'($signed(act[b][j])) * int'($signed(kern[l][b][j]));
                end
            end
            sum_u = sum;
            r.lane[l] = sum_u[dot_pkg::RES_SHIFT +: dot_pkg::RES_W];  // Divide by 256
        end
        return r;
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1, "Simulation stopped at first error");
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            report_failure($sformatf("FAILED at %0t: %s = %b, expected %b",
                                     $time, name, got, exp));
        end
    endtask

    task automatic check_result(input dot_pkg::result_word_t got,
                                input dot_pkg::result_word_t exp);
        for (int l = 0; l < dot_pkg::NUM_LANES; l++) begin
            if (got.lane[l] !== exp.lane[l]) begin
                report_failure($sformatf("FAILED at %0t: o_sum.lane[%0d] = 0x%04h, expected 0x%04h",
                                         $time, l, got.lane[l], exp.lane[l]));
            end
        end
    endtask

    // Outputs sampled mid-cycle, o_valid expected on exactly the listed edge
    always @(negedge i_clk) begin
        exp_valid = (valid_at.size() > 0) && (valid_at[0] == edge_count);
        check_flag("o_valid", o_valid, exp_valid);
        if (exp_valid) begin
            void'(valid_at.pop_front());
            exp_word = exp_q.pop_front();
            check_result(o_sum, exp_word);
            n_checked = n_checked + 1;
        end
    end

    // ------------------------------------------------------------------------
    // Stimulus tasks
    // ------------------------------------------------------------------------
    task automatic step();
        @(posedge i_clk);
        #1;  // Drive just after the edge
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            step();
            i_first = 1'b0;
            i_last  = 1'b0;
            i_a     = rand_vec();  // Ignored outside a product
        end
    endtask

    task automatic write_half(input int l, input int w, input int h, input dot_pkg::half_t d);
        step();
        i_wr_en   = 1'b1;
        i_wr_lane = dot_pkg::lane_id_t'(l);
        i_wr_addr = {dot_pkg::rd_addr_t'(w), 1'(h)};  // LSB picks the half
        i_wr_data = d;
        for (int e = 0; e < dot_pkg::HALF_ELEMS; e++) begin
            kern[l][w][h * dot_pkg::HALF_ELEMS + e] = d[e];  // Half 0 is elements 0..7
        end
    endtask

    // Random kernels, or fixed extremes on lanes 0..2 with lane 3 still random
    task automatic load_kernels(input bit extreme);
        dot_pkg::half_t d;
        for (int l = 0; l < dot_pkg::NUM_LANES; l++) begin
            for (int w = 0; w < dot_pkg::KERNEL_DEPTH; w++) begin
                for (int h = 0; h < 2; h++) begin
                    d = {$urandom, $urandom};
                    if (extreme && l != 3) begin
                        for (int e = 0; e < dot_pkg::HALF_ELEMS; e++) begin
                            if (l == 0)      d[e] = 8'sh80;
                            else if (l == 1) d[e] = 8'sh7f;
                            else             d[e] = e[0] ? 8'sh7f : 8'sh80;  // Alternating
                        end
                    end
                    write_half(l, w, h, d);
                end
            end
        end
        step();
        i_wr_en = 1'b0;
    endtask

    task automatic fill_random(input int n);
        for (int b = 0; b < n; b++) act[b] = rand_vec();
    endtask

    task automatic fill_const(input int n, input dot_pkg::elem_t v);
        for (int b = 0; b < n; b++) act[b] = {dot_pkg::ELEMS{v}};
    endtask

    // Queue the expected word first, then drive n consecutive beats
    task automatic run_product(input int n);
        dot_pkg::result_word_t exp_w;
        exp_w = ref_dot(n);
        exp_q.push_back(exp_w);
        for (int b = 0; b < n; b++) begin
            step();
            i_a     = act[b];
            i_first = (b == 0);
            i_last  = (b == n - 1);
            if (b == n - 1) begin
                valid_at.push_back(edge_count + 1 + LATENCY);  // Next edge samples it
            end
        end
    endtask

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------
    initial begin
        int n;
        void'($urandom(80682));
        i_rst     = 1'b1;
        i_wr_en   = 1'b0;
        i_wr_lane = '0;
        i_wr_addr = '0;
        i_wr_data = '0;
        i_a       = '0;
        i_first   = 1'b0;
        i_last    = 1'b0;
        repeat (2) @(posedge i_clk);
        #1;
        i_rst = 1'b0;
        idle(4);  // o_valid must stay low here

        load_kernels(1'b0);
        for (int p = 0; p < N_SINGLE; p++) begin
            fill_random(1);  // First and last together
            run_product(1);
            idle(DRAIN);
        end

        for (int p = 0; p < N_MULTI; p++) begin
            n = 2 + int'($urandom % 63);  // 2 to 64 beats
            fill_random(n);
            run_product(n);
            idle(DRAIN);
        end

        // No gap between i_last and the next i_first
        for (int p = 0; p < N_B2B; p++) begin
            n = 1 + int'($urandom % dot_pkg::KERNEL_DEPTH);
            fill_random(n);
            run_product(n);
        end
        idle(DRAIN);

        load_kernels(1'b1);
        fill_const(dot_pkg::KERNEL_DEPTH, dot_pkg::elem_t'(-128));
        run_product(dot_pkg::KERNEL_DEPTH);
        idle(DRAIN);
        fill_const(dot_pkg::KERNEL_DEPTH, dot_pkg::elem_t'(127));
        run_product(dot_pkg::KERNEL_DEPTH);
        idle(DRAIN);
        fill_const(40, dot_pkg::elem_t'(-128));
        run_product(40);
        idle(DRAIN);
        fill_const(57, dot_pkg::elem_t'(127));
        run_product(57);
        idle(DRAIN);

        while (valid_at.size() != 0) @(posedge i_clk);  // Watchdog bounds this
        @(posedge i_clk);
        if (n_checked != N_PRODUCTS || exp_q.size() != 0) begin
            report_failure($sformatf("Expected %0d results but checked %0d",
                                     N_PRODUCTS, n_checked));
        end else begin
            $display("Result: PASSED");
            $finish;
        end
    end

    // Run length bound from the number of writes, beats and drain cycles
    initial begin
        #((RUN_CYCLES + 200) * CLK_PERIOD);
        report_failure($sformatf("Timeout: run did not finish within %0d cycles",
                                 RUN_CYCLES + 200));
    end

endmodule

/* src.f */
logic/dot_pkg.sv
logic/dot_input_stage.sv
logic/dot_kernel_bank.sv
logic/dot_lane.sv
logic/dot_result_collect.sv
logic/dot_product_top.sv
verification/dot_product_tb.sv

/* Makefile */
# Verilator build, run, lint and clean for the dot-product engine

VERILATOR  ?= verilator
TOP        := dot_product_tb
FILELIST   := src.f
OBJ_DIR    := obj_dir
LOG        := sim.log
VFLAGS     := --binary --timing --assert -j 0 --top-module $(TOP) -Mdir $(OBJ_DIR)
LINT_FLAGS := --lint-only --timing --assert --top-module $(TOP)
SOURCES    := $(shell cat $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

# Pass only when the log holds the pass line
run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "Result: PASSED" $(LOG) || (echo "Simulation did not pass"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
